//--- spec_uart_pkg.sv
// Shared types and constants for the spectrum UART core, imported by every RTL file and the testbench
package spec_uart_pkg;

    // Width of one fixed-point component word
    localparam int SAMPLE_W = 28;

    localparam int BYTE_W = 8;  // Width of one byte lane and one serial payload

    // One component word, seen either as a whole signed value or as its byte fields
    typedef union packed {
        logic signed [SAMPLE_W-1:0] value;
        struct packed {
            logic [5:0]        guard;    // Bits 27 to 22, not sent
            logic [BYTE_W-1:0] hi_byte;  // Bits 21 to 14
            logic [BYTE_W-1:0] lo_byte;  // Bits 13 to 6
            logic [5:0]        frac;     // Bits 5 to 0, dropped without rounding
        } fields;
    } spec_sample_u;

    // Byte lane selected when a bank is read
    typedef enum logic {
        LANE_LO,
        LANE_HI
    } lane_e;

    // Send passes, in the order they go out on the line
    typedef enum logic [1:0] {
        PASS_RE_LO,
        PASS_RE_HI,
        PASS_IM_LO,
        PASS_IM_HI
    } pass_e;

    // A frame is a mark bit, a start bit, eight data bits and a stop bit
    localparam int FRAME_BITS  = 11;
    localparam int FRAME_IDX_W = $clog2(FRAME_BITS);
    localparam int BIT_MARK    = 0;
    localparam int BIT_START   = 1;
    localparam int BIT_STOP    = FRAME_BITS - 1;

endpackage

//--- tx_byte_if.sv
// Byte handoff from the frame sequencer to the UART transmitter with start, busy and done handshake
interface tx_byte_if import spec_uart_pkg::*; ();

    logic              start;  // One-cycle request, only while busy is low
    logic [BYTE_W-1:0] data;   // Sampled by the transmitter in the start cycle
    logic              busy;   // High while a frame is on the line
    logic              done;   // One-cycle pulse in the last cycle of the stop bit

    // The sequencer owns the request side
    modport source (
        output start,
        output data,
        input  busy,
        input  done
    );

    // The transmitter owns the status side
    modport sink (
        input  start,
        input  data,
        output busy,
        output done
    );

endinterface

//--- sample_bank.sv
// Byte lane store for one complex component that is written per sample and read by index
module sample_bank import spec_uart_pkg::*; #(
    parameter int DEPTH = 32
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     wr_en_i,
    input  logic [$clog2(DEPTH)-1:0] wr_idx_i,
    input  spec_sample_u             sample_i,
    input  logic [$clog2(DEPTH)-1:0] rd_idx_i,
    input  lane_e                    lane_i,
    output logic [BYTE_W-1:0]        byte_o
);

    logic [BYTE_W-1:0] lo_mem [DEPTH];
    logic [BYTE_W-1:0] hi_mem [DEPTH];

    // Marks entries written since reset so that unwritten slots read as zero
    logic [DEPTH-1:0] written_q;

    // Only the two middle fields are stored
    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            lo_mem[wr_idx_i] <= sample_i.fields.lo_byte;
            hi_mem[wr_idx_i] <= sample_i.fields.hi_byte;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            written_q <= '0;
        end else if (wr_en_i) begin
            written_q[wr_idx_i] <= 1'b1;
        end
    end

    // Asynchronous read so the sequencer sees the byte in the same cycle it sets the index
    always_comb begin
        if (!written_q[rd_idx_i]) begin
            byte_o = '0;
        end else if (lane_i == LANE_HI) begin
            byte_o = hi_mem[rd_idx_i];
        end else begin
            byte_o = lo_mem[rd_idx_i];
        end
    end

endmodule

//--- frame_sequencer.sv
// Capture control and send ordering: fills both banks, then walks the four passes and hands bytes to the UART
module frame_sequencer import spec_uart_pkg::*; #(
    parameter int DEPTH = 32
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     en_i,
    input  logic [BYTE_W-1:0]        re_byte_i,
    input  logic [BYTE_W-1:0]        im_byte_i,
    output logic                     wr_en_o,
    output logic [$clog2(DEPTH)-1:0] wr_idx_o,
    output logic [$clog2(DEPTH)-1:0] rd_idx_o,
    output lane_e                    lane_o,
    output logic                     busy_o,
    tx_byte_if.source                tx
);

    localparam int IDX_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);  // Write count has to reach DEPTH

    localparam logic [1:0] S_CAPTURE = 2'd0;
    localparam logic [1:0] S_ISSUE   = 2'd1;
    localparam logic [1:0] S_WAIT    = 2'd2;

    logic [1:0]       state_q;
    logic [CNT_W-1:0] wr_ptr_q;
    logic [IDX_W-1:0] rd_ptr_q;
    pass_e            pass_q;
    logic             start_q;
    logic             busy_q;

    logic last_sample;
    logic last_index;
    logic last_byte;
    logic pass_is_re;

    assign last_sample = (wr_ptr_q == CNT_W'(DEPTH - 1));
    assign last_index  = (rd_ptr_q == IDX_W'(DEPTH - 1));
    assign last_byte   = last_index && (pass_q == PASS_IM_HI);

    // The pass alone decides the lane and the component
    assign pass_is_re = (pass_q == PASS_RE_LO) || (pass_q == PASS_RE_HI);
    assign lane_o     = ((pass_q == PASS_RE_HI) || (pass_q == PASS_IM_HI)) ? LANE_HI : LANE_LO;

    // Strobes outside capture are dropped here
    assign wr_en_o  = (state_q == S_CAPTURE) && en_i;
    assign wr_idx_o = wr_ptr_q[IDX_W-1:0];
    assign rd_idx_o = rd_ptr_q;

    assign tx.start = start_q;
    assign tx.data  = pass_is_re ? re_byte_i : im_byte_i;  // Held stable until the next done
    assign busy_o   = busy_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q  <= S_CAPTURE;
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            pass_q   <= PASS_RE_LO;
            start_q  <= 1'b0;
            busy_q   <= 1'b0;
        end else begin
            start_q <= 1'b0;  // Start is a single-cycle request

            case (state_q)
                S_CAPTURE: begin
                    if (en_i) begin
                        wr_ptr_q <= wr_ptr_q + 1'b1;
                        if (last_sample) begin
                            // Busy rises on the edge that writes the final sample
                            state_q <= S_ISSUE;
                            busy_q  <= 1'b1;
                        end
                    end
                end

                S_ISSUE: begin
                    // First byte of the burst
                    if (!tx.busy) begin
                        start_q <= 1'b1;
                        state_q <= S_WAIT;
                    end
                end

                S_WAIT: begin
                    if (tx.done) begin
                        if (last_byte) begin
                            // Block sent, so rewind everything and capture again
                            state_q  <= S_CAPTURE;
                            busy_q   <= 1'b0;
                            wr_ptr_q <= '0;
                            rd_ptr_q <= '0;
                            pass_q   <= PASS_RE_LO;
                        end else begin
                            start_q <= 1'b1;  // Next byte goes in the cycle after done
                            if (last_index) begin
                                rd_ptr_q <= '0;
                                pass_q   <= pass_e'(pass_q + 2'd1);
                            end else begin
                                rd_ptr_q <= rd_ptr_q + 1'b1;
                            end
                        end
                    end
                end

                default: begin
                    state_q <= S_CAPTURE;
                end
            endcase
        end
    end

endmodule

//--- uart_byte_tx.sv
// Serial transmitter that sends one byte per start request as mark, start, eight data bits and stop
module uart_byte_tx import spec_uart_pkg::*; #(
    parameter int BIT_CYCLES = 5207
) (
    input  logic   clk,
    input  logic   rst_n,
    tx_byte_if.sink tx,
    output logic   tx_o
);

    // Bit period is BIT_CYCLES+1 clocks
    localparam int CNT_W = (BIT_CYCLES > 0) ? $clog2(BIT_CYCLES + 1) : 1;

    localparam logic [CNT_W-1:0]       CNT_LAST  = CNT_W'(BIT_CYCLES);
    localparam logic [FRAME_IDX_W-1:0] IDX_MARK  = FRAME_IDX_W'(BIT_MARK);
    localparam logic [FRAME_IDX_W-1:0] IDX_START = FRAME_IDX_W'(BIT_START);
    localparam logic [FRAME_IDX_W-1:0] IDX_STOP  = FRAME_IDX_W'(BIT_STOP);

    logic                   active_q;
    logic [CNT_W-1:0]       cnt_q;
    logic [FRAME_IDX_W-1:0] bit_idx_q;
    logic [BYTE_W-1:0]      shreg_q;

    logic                   bit_end;
    logic [FRAME_IDX_W-1:0] next_idx;

    assign bit_end  = (cnt_q == CNT_LAST);
    assign next_idx = bit_idx_q + 1'b1;

    assign tx.busy = active_q;
    assign tx.done = active_q && bit_end && (bit_idx_q == IDX_STOP);  // Last cycle of the stop bit

    // Data shift register, loaded on start and shifted as each data bit begins
    always_ff @(posedge clk) begin
        if (!active_q && tx.start) begin
            shreg_q <= tx.data;
        end else if (active_q && bit_end && next_idx != IDX_START && next_idx != IDX_STOP &&
                     bit_idx_q != IDX_STOP) begin
            shreg_q <= shreg_q >> 1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active_q  <= 1'b0;
            cnt_q     <= '0;
            bit_idx_q <= '0;
            tx_o      <= 1'b1;  // Line idles high
        end else if (!active_q) begin
            cnt_q <= '0;  // Counter only runs inside a frame
            if (tx.start) begin
                active_q  <= 1'b1;
                bit_idx_q <= IDX_MARK;
                tx_o      <= 1'b1;  // Mark bit
            end
        end else if (bit_end) begin
            cnt_q <= '0;
            if (bit_idx_q == IDX_STOP) begin
                active_q <= 1'b0;
                tx_o     <= 1'b1;
            end else begin
                bit_idx_q <= next_idx;
                if (next_idx == IDX_START) begin
                    tx_o <= 1'b0;
                end else if (next_idx == IDX_STOP) begin
                    tx_o <= 1'b1;
                end else begin
                    tx_o <= shreg_q[0];  // Data goes out LSB first
                end
            end
        end else begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

endmodule

//--- spectrum_uart_top.sv
// Top level of the spectrum UART core: sets block depth and bit time and wires banks, sequencer and UART
module spectrum_uart_top import spec_uart_pkg::*; #(
    parameter int DEPTH      = 32,
    parameter int BIT_CYCLES = 5207
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                en_i,
    input  logic [SAMPLE_W-1:0] data_re_i,
    input  logic [SAMPLE_W-1:0] data_im_i,
    output logic                tx_o,
    output logic                tx_done_o,
    output logic                busy_o
);

    localparam int IDX_W = $clog2(DEPTH);

    logic              wr_en;
    logic [IDX_W-1:0]  wr_idx;
    logic [IDX_W-1:0]  rd_idx;
    lane_e             lane;
    logic [BYTE_W-1:0] re_byte;
    logic [BYTE_W-1:0] im_byte;

    tx_byte_if tx_if ();

    // Both banks share write and read addressing and differ only in the sample they store
    sample_bank #(
        .DEPTH(DEPTH)
    ) u_bank_re (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_en_i (wr_en),
        .wr_idx_i(wr_idx),
        .sample_i(data_re_i),
        .rd_idx_i(rd_idx),
        .lane_i  (lane),
        .byte_o  (re_byte)
    );

    sample_bank #(
        .DEPTH(DEPTH)
    ) u_bank_im (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_en_i (wr_en),
        .wr_idx_i(wr_idx),
        .sample_i(data_im_i),
        .rd_idx_i(rd_idx),
        .lane_i  (lane),
        .byte_o  (im_byte)
    );

    frame_sequencer #(
        .DEPTH(DEPTH)
    ) u_seq (
        .clk      (clk),
        .rst_n    (rst_n),
        .en_i     (en_i),
        .re_byte_i(re_byte),
        .im_byte_i(im_byte),
        .wr_en_o  (wr_en),
        .wr_idx_o (wr_idx),
        .rd_idx_o (rd_idx),
        .lane_o   (lane),
        .busy_o   (busy_o),
        .tx       (tx_if)
    );

    uart_byte_tx #(
        .BIT_CYCLES(BIT_CYCLES)
    ) u_tx (
        .clk  (clk),
        .rst_n(rst_n),
        .tx   (tx_if),
        .tx_o (tx_o)
    );

    assign tx_done_o = tx_if.done;  // Per-byte strobe, same cycle as the handshake done

endmodule

//--- tb_clkgen.sv
// Testbench clock and reset source, instantiated once by the testbench top to drive clk and rst_n
module tb_clkgen #(
    parameter int PERIOD       = 40,
    parameter int RESET_CYCLES = 5
) (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever begin
            #(PERIOD / 2);
            clk_o = ~clk_o;
        end
    end

    // Reset lets go a little after a rising edge, like every other input
    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #2;
        rst_n_o = 1'b1;
    end

endmodule

//--- tb_spectrum_uart.sv
// Testbench top for the spectrum UART core: captures random blocks, decodes the line and checks strobes
module tb_spectrum_uart import spec_uart_pkg::*; ();

    localparam int DEPTH       = 8;
    localparam int BIT_CYCLES  = 9;
    localparam int BIT_P       = BIT_CYCLES + 1;  // Clock cycles per serial bit
    localparam int FRAME_CYC   = FRAME_BITS * BIT_P;
    localparam int BURST_BYTES = 4 * DEPTH;
    localparam int RESET_CYC   = 5;
    localparam int LIMIT_CYC   = 2 * BURST_BYTES * FRAME_CYC + 2 * (2 * DEPTH + 2) + RESET_CYC + 500;

    logic                clk;
    logic                rst_n;
    logic                en_i;
    logic [SAMPLE_W-1:0] data_re_i;
    logic [SAMPLE_W-1:0] data_im_i;
    logic                tx_o;
    logic                tx_done_o;
    logic                busy_o;

    logic [7:0] exp_q [$];  // Bytes the line still owes us, in send order
    integer     seed;
    int         val_errs   = 0;
    int         other_errs = 0;
    int         rx_count   = 0;

    // Monitor state, touched only by the negedge monitor
    int   cyc           = 0;
    int   rise_cyc      = 0;
    int   done_cnt      = 0;
    int   captures      = 0;
    logic done_prev     = 1'b0;
    logic busy_prev     = 1'b0;
    logic first_pending = 1'b0;

    tb_clkgen #(.PERIOD(40), .RESET_CYCLES(RESET_CYC)) u_clkgen (.clk_o(clk), .rst_n_o(rst_n));

    spectrum_uart_top #(
        .DEPTH     (DEPTH),
        .BIT_CYCLES(BIT_CYCLES)
    ) DUT (
        .clk      (clk),
        .rst_n    (rst_n),
        .en_i     (en_i),
        .data_re_i(data_re_i),
        .data_im_i(data_im_i),
        .tx_o     (tx_o),
        .tx_done_o(tx_done_o),
        .busy_o   (busy_o)
    );

    task automatic finish_run();
        $display("Errors: %0d value, %0d other, %0d total", val_errs, other_errs,
                 val_errs + other_errs);
        if (val_errs + other_errs == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    endtask

    // Strobes DEPTH random samples and queues the bytes they should produce
    task automatic capture_block();
        spec_sample_u        re_s;
        spec_sample_u        im_s;
        logic [SAMPLE_W-1:0] re_v [DEPTH];
        logic [SAMPLE_W-1:0] im_v [DEPTH];
        for (int i = 0; i < DEPTH; i++) begin
            @(posedge clk);
            #2;
            re_s.value = SAMPLE_W'($random(seed));  // Guard and frac bits vary too
            im_s.value = SAMPLE_W'($random(seed));
            en_i       = 1'b1;
            data_re_i  = re_s;
            data_im_i  = im_s;
            re_v[i]    = re_s;
            im_v[i]    = im_s;
        end
        @(posedge clk);
        #2;
        en_i = 1'b0;
        // Low byte is bits 13 to 6, high byte is bits 21 to 14
        for (int i = 0; i < DEPTH; i++) exp_q.push_back(re_v[i][13:6]);
        for (int i = 0; i < DEPTH; i++) exp_q.push_back(re_v[i][21:14]);
        for (int i = 0; i < DEPTH; i++) exp_q.push_back(im_v[i][13:6]);
        for (int i = 0; i < DEPTH; i++) exp_q.push_back(im_v[i][21:14]);
    endtask

    // New values while a block is on the line, none of which may ever be sent
    task automatic strobe_during_burst(input int count);
        for (int i = 0; i < count; i++) begin
            @(posedge clk);
            #2;
            assert (busy_o) else begin
                other_errs++;
                $display("A strobe meant to be dropped was issued while busy_o was low");
            end
            en_i      = 1'b1;
            data_re_i = SAMPLE_W'($random(seed));
            data_im_i = SAMPLE_W'($random(seed));
        end
        @(posedge clk);
        #2;
        en_i = 1'b0;
    endtask

    task automatic wait_busy_low();
        @(negedge clk);
        while (busy_o) @(negedge clk);
    endtask

    // Called on the first negedge of a bit period, returns on the first negedge of the next one
    task automatic read_period(output logic bit_val);
        logic first;
        first   = tx_o;
        bit_val = first;
        for (int i = 1; i < BIT_P; i++) begin
            @(negedge clk);
            if (i == BIT_P / 2) bit_val = tx_o;  // Middle of the bit
            assert (tx_o === first) else begin
                other_errs++;
                $display("tx_o changed in the middle of a bit period at t=%0t", $time);
            end
        end
        @(negedge clk);
    endtask

    task automatic check_byte(input logic [7:0] rx);
        logic [7:0] exp;
        assert (exp_q.size() > 0) else begin
            other_errs++;
            $display("Byte 0x%02h arrived when no more bytes were expected", rx);
        end
        if (exp_q.size() > 0) begin
            exp = exp_q.pop_front();
            assert (rx === exp) else begin
                val_errs++;
                $display("ERR %0t: byte %0d is 0x%02h, expected 0x%02h", $time, rx_count, rx, exp);
            end
        end
        rx_count++;
    endtask

    task automatic decode_frame();
        int         high_run;
        logic       b;
        logic [7:0] rx;
        high_run = 0;
        while (tx_o !== 1'b0) begin  // Idle and mark bit until the start bit falls
            high_run++;
            @(negedge clk);
        end
        assert (high_run >= BIT_P) else begin
            other_errs++;
            $display("Mark bit before the start bit lasted only %0d cycles", high_run);
        end
        read_period(b);
        assert (b === 1'b0) else begin
            val_errs++;
            $display("ERR %0t: start bit sampled high", $time);
        end
        for (int i = 0; i < 8; i++) begin
            read_period(b);
            rx[i] = b;  // LSB first
        end
        read_period(b);
        assert (b === 1'b1) else begin
            val_errs++;
            $display("ERR %0t: stop bit sampled low", $time);
        end
        check_byte(rx);
    endtask

    initial begin : line_decoder
        @(negedge clk);
        forever decode_frame();
    end

    always @(negedge clk) begin
        if (captures < DEPTH) begin
            assert (tx_o === 1'b1 && tx_done_o === 1'b0 && busy_o === 1'b0) else begin
                val_errs++;
                $display("ERR %0t: tx_o=%b tx_done_o=%b busy_o=%b before the first block",
                         $time, tx_o, tx_done_o, busy_o);
            end
        end
        if (rst_n && en_i && !busy_o) captures++;
        if (busy_o && !busy_prev) begin
            rise_cyc      = cyc;
            done_cnt      = 0;
            first_pending = 1'b1;
        end
        if (tx_done_o) begin
            assert (!done_prev) else begin
                other_errs++;
                $display("tx_done_o stayed high for more than one cycle at t=%0t", $time);
            end
            assert (busy_o) else begin
                other_errs++;
                $display("tx_done_o pulsed while busy_o was low at t=%0t", $time);
            end
            done_cnt++;
            if (first_pending) begin
                assert (cyc - rise_cyc == FRAME_CYC + 1) else begin
                    val_errs++;
                    $display("ERR %0t: first tx_done_o came %0d cycles after busy_o, expected %0d",
                             $time, cyc - rise_cyc, FRAME_CYC + 1);
                end
                first_pending = 1'b0;
            end
        end
        if (!busy_o && busy_prev) begin
            assert (done_prev) else begin
                other_errs++;
                $display("busy_o fell without a tx_done_o pulse at t=%0t", $time);
            end
            assert (done_cnt == BURST_BYTES) else begin
                val_errs++;
                $display("ERR %0t: %0d tx_done_o pulses in a burst, expected %0d",
                         $time, done_cnt, BURST_BYTES);
            end
        end
        done_prev = tx_done_o;
        busy_prev = busy_o;
        cyc++;
    end

    initial begin : watchdog
        @(negedge clk);
        while (cyc < LIMIT_CYC) @(negedge clk);
        other_errs++;
        $display("Timeout: the run did not finish within %0d clock cycles", LIMIT_CYC);
        finish_run();
    end

    initial begin : stimulus
        en_i      = 1'b0;
        data_re_i = '0;
        data_im_i = '0;
        seed      = 41178;
        @(posedge rst_n);
        capture_block();
        strobe_during_burst(DEPTH);
        wait_busy_low();
        capture_block();  // Second block checks that both pointers start over at zero
        wait_busy_low();
        repeat (2 * BIT_P) @(negedge clk);  // Lets the decoder finish the last stop bit
        assert (exp_q.size() == 0) else begin
            other_errs++;
            $display("%0d expected bytes never appeared on the line", exp_q.size());
        end
        finish_run();
    end

endmodule

//--- sim.f
spec_uart_pkg.sv
tx_byte_if.sv
sample_bank.sv
frame_sequencer.sv
uart_byte_tx.sv
spectrum_uart_top.sv
tb_clkgen.sv
tb_spectrum_uart.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_spectrum_uart
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	elif ! grep -q "TEST PASSED" $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
